//--- design/sdCfgPkg.sv
`default_nettype none

package sdCfgPkg;

    // ==============================
    // Configuration request
    // ==============================
    typedef enum logic {
        CfgReset = 1'b0,
        CfgInit  = 1'b1
    } cfgAction_t;

    typedef enum logic {
        ClkSlow = 1'b0,
        ClkFast = 1'b1
    } clkSpeed_t;

    typedef struct packed {
        cfgAction_t action;
        clkSpeed_t  clkSpeed;
    } cfgReq_t;

    // ==============================
    // Card clock divider
    // ==============================
    localparam int DivWidth = 4;

    // Slow speed is scaled down from 400 kHz to keep simulations short
    localparam logic [DivWidth-1:0] SlowHalfPeriod = 4'd8;
    localparam logic [DivWidth-1:0] FastHalfPeriod = 4'd1;

    // Clock stays stopped this long before and after a speed change
    localparam int SettleCycles = 4;

endpackage

`default_nettype wire

//--- design/sdCmdPkg.sv
`default_nettype none

package sdCmdPkg;

    // ==============================
    // Frame lengths
    // ==============================
    localparam int CmdLen        = 48;
    localparam int CmdPayloadLen = 40;
    localparam int ShortRespLen  = 48;
    localparam int LongRespLen   = 136;

    // Leading bits of a long response that the CRC does not cover
    localparam int LongCrcSkip   = 8;

    // ==============================
    // CRC7 with x^7 + x^3 + 1
    // ==============================
    localparam int Crc7Len = 7;
    localparam logic [Crc7Len-1:0] Crc7Poly = 7'h09;

    // ==============================
    // Command and response
    // ==============================
    typedef enum logic [1:0] {
        RespNone  = 2'b00,
        RespShort = 2'b01,
        RespLong  = 2'b10
    } respType_t;

    typedef struct packed {
        logic [CmdLen-1:0] data;
        respType_t         respType;
    } cmdReq_t;

    // Short responses sit in the low bits of data
    typedef struct packed {
        logic [LongRespLen-1:0] data;
        logic                   crcErr;
    } respResult_t;

endpackage

`default_nettype wire

//--- design/sdCrc7.sv
`default_nettype none
`timescale 1ns/100ps

module sdCrc7
    import sdCmdPkg::*;
(
    input  logic               clk_fast,
    input  logic               rstN,
    input  logic               clear,
    input  logic               en,
    input  logic               bitIn,
    output logic [Crc7Len-1:0] crc
);

    logic feedback;

    assign feedback = bitIn ^ crc[Crc7Len-1];

    // Serial form, MSB first
    always_ff @(posedge clk_fast or negedge rstN) begin
        if (!rstN) begin
            crc <= '0;
        end else if (clear) begin
            crc <= '0;
        end else if (en) begin
            crc <= {crc[Crc7Len-2:0], 1'b0} ^ (feedback ? Crc7Poly : '0);
        end
    end

endmodule

`default_nettype wire

//--- design/sdClockGen.sv
`default_nettype none
`timescale 1ns/100ps

module sdClockGen
    import sdCfgPkg::*;
(
    input  logic      clk_fast,
    input  logic      rstN,
    input  logic      clkRun,
    input  clkSpeed_t clkSpeed,
    output logic      sdClk,
    output logic      riseTick,
    output logic      fallTick
);

    logic [DivWidth-1:0] divCnt;
    logic [DivWidth-1:0] halfPeriod;
    logic                clkLevel;
    logic                expire;
    logic                riseReg;
    logic                fallReg;

    assign halfPeriod = (clkSpeed == ClkFast) ? FastHalfPeriod : SlowHalfPeriod;
    assign expire     = (divCnt == halfPeriod - 1'b1);

    // Stopping forces the pin low without waiting for the next edge
    assign sdClk    = clkLevel & clkRun;
    assign riseTick = riseReg & clkRun;
    assign fallTick = fallReg & clkRun;

    always_ff @(posedge clk_fast or negedge rstN) begin
        if (!rstN) begin
            divCnt   <= '0;
            clkLevel <= 1'b0;
            riseReg  <= 1'b0;
            fallReg  <= 1'b0;
        end else begin
            riseReg <= 1'b0;
            fallReg <= 1'b0;
            if (!clkRun) begin
                divCnt   <= '0;
                clkLevel <= 1'b0;
            end else if (expire) begin
                divCnt   <= '0;
                clkLevel <= ~clkLevel;
                // Strobe matches the level being entered
                riseReg  <= ~clkLevel;
                fallReg  <= clkLevel;
            end else begin
                divCnt <= divCnt + 1'b1;
            end
        end
    end

    // Strobes are exclusive and a rise strobe marks a real low-to-high edge
    tickEdges: assert property (@(posedge clk_fast) disable iff (!rstN)
        riseTick |-> !fallTick && sdClk && !$past(sdClk));

endmodule

`default_nettype wire

//--- design/sdConfigRegs.sv
`default_nettype none
`timescale 1ns/100ps

module sdConfigRegs
    import sdCfgPkg::*;
(
    input  logic      clk_fast,
    input  logic      rstN,
    input  logic      cfgWrite,
    input  cfgReq_t   cfgReq,
    output logic      clkRun,
    output clkSpeed_t clkSpeed,
    output logic      ready
);

    typedef enum logic [1:0] {
        CfgIdle,
        CfgStop,
        CfgRestart
    } cfgState_t;

    cfgState_t                           state;
    logic [$clog2(SettleCycles)-1:0]     settleCnt;
    cfgReq_t                             pending;

    // ==============================
    // Stop, apply, restart
    // ==============================
    always_ff @(posedge clk_fast or negedge rstN) begin
        if (!rstN) begin
            state     <= CfgIdle;
            settleCnt <= '0;
            clkRun    <= 1'b1;
            clkSpeed  <= ClkSlow;
            ready     <= 1'b0;
        end else begin
            case (state)
                CfgStop: begin
                    if (settleCnt == '0) begin
                        // New setting loads once the clock has been stopped long enough
                        if (pending.action == CfgReset) begin
                            clkSpeed <= ClkSlow;
                            ready    <= 1'b0;
                        end else begin
                            clkSpeed <= pending.clkSpeed;
                            ready    <= 1'b1;
                        end
                        settleCnt <= ($clog2(SettleCycles))'(SettleCycles - 1);
                        state     <= CfgRestart;
                    end else begin
                        settleCnt <= settleCnt - 1'b1;
                    end
                end
                CfgRestart: begin
                    if (settleCnt == '0) begin
                        clkRun <= 1'b1;
                        state  <= CfgIdle;
                    end else begin
                        settleCnt <= settleCnt - 1'b1;
                    end
                end
                default: begin
                end
            endcase

            // A new write restarts the sequence from the top
            if (cfgWrite) begin
                clkRun    <= 1'b0;
                settleCnt <= ($clog2(SettleCycles))'(SettleCycles - 1);
                state     <= CfgStop;
            end
        end
    end

    always_ff @(posedge clk_fast) begin
        if (cfgWrite) begin
            pending <= cfgReq;
        end
    end

    speedChangeStopped: assert property (@(posedge clk_fast) disable iff (!rstN)
        $changed(clkSpeed) |-> !clkRun);

endmodule

`default_nettype wire

//--- design/sdCmdTx.sv
`default_nettype none
`timescale 1ns/100ps

module sdCmdTx
    import sdCmdPkg::*;
(
    input  logic      clk_fast,
    input  logic      rstN,
    input  logic      ready,
    input  logic      fallTick,
    input  logic      cmdStart,
    input  cmdReq_t   cmdReq,
    output logic      sdCmdOut,
    output logic      sdCmdOe,
    output logic      cmdDone,
    output respType_t respType
);

    logic               busy;
    logic [5:0]         bitCnt;
    logic [CmdLen-1:0]  shiftReg;
    respType_t          respTypeReg;
    logic [Crc7Len-1:0] crc;
    logic               startNew;
    logic               sendPayload;
    logic               lastTick;
    logic [5:0]         crcIdx;
    logic               txBit;

    assign startNew    = cmdStart & ready;
    assign sendPayload = busy & fallTick & (bitCnt < 6'(CmdPayloadLen));
    // Fall edge after the end bit closes the frame
    assign lastTick    = busy & fallTick & (bitCnt == 6'(CmdLen));
    assign crcIdx      = 6'(CmdLen - 2) - bitCnt;

    // ==============================
    // Bit select of payload then CRC then end bit
    // ==============================
    always_comb begin
        if (bitCnt < 6'(CmdPayloadLen)) begin
            txBit = shiftReg[CmdLen-1];
        end else if (bitCnt < 6'(CmdLen - 1)) begin
            txBit = crc[crcIdx[2:0]];
        end else begin
            txBit = 1'b1;
        end
    end

    assign cmdDone  = lastTick & ready & ~cmdStart;
    assign respType = respTypeReg;

    always_ff @(posedge clk_fast or negedge rstN) begin
        if (!rstN) begin
            busy     <= 1'b0;
            bitCnt   <= '0;
            sdCmdOut <= 1'b1;
            sdCmdOe  <= 1'b0;
        end else if (startNew) begin
            // Also aborts a frame in flight
            busy     <= 1'b1;
            bitCnt   <= '0;
            sdCmdOut <= 1'b1;
            sdCmdOe  <= 1'b0;
        end else if (!ready || lastTick) begin
            busy     <= 1'b0;
            sdCmdOut <= 1'b1;
            sdCmdOe  <= 1'b0;
        end else if (busy && fallTick) begin
            sdCmdOut <= txBit;
            sdCmdOe  <= 1'b1;
            bitCnt   <= bitCnt + 1'b1;
        end
    end

    always_ff @(posedge clk_fast) begin
        if (startNew) begin
            shiftReg    <= cmdReq.data;
            respTypeReg <= cmdReq.respType;
        end else if (sendPayload) begin
            shiftReg <= {shiftReg[CmdLen-2:0], 1'b0};
        end
    end

    sdCrc7 txCrc (
        .clk_fast (clk_fast),
        .rstN     (rstN),
        .clear    (startNew),
        .en       (sendPayload),
        .bitIn    (shiftReg[CmdLen-1]),
        .crc      (crc)
    );

endmodule

`default_nettype wire

//--- design/sdRespRx.sv
`default_nettype none
`timescale 1ns/100ps

module sdRespRx
    import sdCmdPkg::*;
(
    input  logic        clk_fast,
    input  logic        rstN,
    input  logic        ready,
    input  logic        riseTick,
    input  logic        cmdDone,
    input  respType_t   respType,
    input  logic        sdCmdIn,
    output logic        respDone,
    output respResult_t respResult
);

    typedef enum logic [1:0] {
        RxIdle,
        RxWait,
        RxRecv
    } rxState_t;

    rxState_t               state;
    logic                   longResp;
    logic [7:0]             bitCnt;
    logic [LongRespLen-1:0] shiftReg;
    logic [Crc7Len-1:0]     crc;
    logic                   armed;
    logic                   sampleNow;
    logic                   crcEn;
    logic                   lastBit;
    logic                   finish;
    logic [7:0]             curIdx;
    logic [7:0]             frameLen;
    logic [7:0]             skipLen;

    // Seen by the top-level check against the CMD driver
    assign armed = (state != RxIdle);

    assign frameLen = longResp ? 8'(LongRespLen) : 8'(ShortRespLen);
    assign skipLen  = longResp ? 8'(LongCrcSkip) : 8'd0;

    // Start bit counts as bit 0 of the frame
    assign sampleNow = riseTick & ((state == RxRecv) | ((state == RxWait) & ~sdCmdIn));
    assign curIdx    = (state == RxRecv) ? bitCnt : 8'd0;
    assign crcEn     = sampleNow & (curIdx >= skipLen) & (curIdx < frameLen - 8'(Crc7Len + 1));
    assign lastBit   = sampleNow & (curIdx == frameLen - 8'd1);
    assign finish    = lastBit & ready & ~cmdDone;

    // ==============================
    // Receive FSM
    // ==============================
    always_ff @(posedge clk_fast or negedge rstN) begin
        if (!rstN) begin
            state    <= RxIdle;
            longResp <= 1'b0;
            bitCnt   <= '0;
            respDone <= 1'b0;
        end else begin
            respDone <= 1'b0;
            if (!ready) begin
                state <= RxIdle;
            end else if (cmdDone) begin
                longResp <= (respType == RespLong);
                state    <= (respType == RespNone) ? RxIdle : RxWait;
            end else begin
                case (state)
                    RxWait: begin
                        if (sampleNow) begin
                            bitCnt <= 8'd1;
                            state  <= RxRecv;
                        end
                    end
                    RxRecv: begin
                        if (finish) begin
                            respDone <= 1'b1;
                            state    <= RxIdle;
                        end else if (sampleNow) begin
                            bitCnt <= bitCnt + 1'b1;
                        end
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // Last bit goes straight into the result and respDone follows one cycle later
    always_ff @(posedge clk_fast) begin
        if (sampleNow) begin
            shiftReg <= {shiftReg[LongRespLen-2:0], sdCmdIn};
        end
        if (finish) begin
            if (longResp) begin
                respResult.data <= {shiftReg[LongRespLen-2:0], sdCmdIn};
            end else begin
                respResult.data <= {{(LongRespLen - ShortRespLen){1'b0}},
                                    shiftReg[ShortRespLen-2:0], sdCmdIn};
            end
            // CRC field sits just above the end bit
            respResult.crcErr <= (shiftReg[Crc7Len-1:0] != crc) | ~sdCmdIn;
        end
    end

    sdCrc7 rxCrc (
        .clk_fast (clk_fast),
        .rstN     (rstN),
        .clear    (cmdDone),
        .en       (crcEn),
        .bitIn    (sdCmdIn),
        .crc      (crc)
    );

endmodule

`default_nettype wire

//--- design/sdController.sv
`default_nettype none
`timescale 1ns/100ps

module sdController
    import sdCfgPkg::*;
    import sdCmdPkg::*;
(
    input  logic        clk_fast,
    input  logic        rstN,
    input  logic        cfgWrite,
    input  cfgReq_t     cfgReq,
    input  logic        cmdStart,
    input  cmdReq_t     cmdReq,
    output logic        cmdDone,
    output logic        respDone,
    output respResult_t respResult,
    output logic        sdClk,
    output logic        sdCmdOut,
    output logic        sdCmdOe,
    input  logic        sdCmdIn
);

    logic      clkRun;
    clkSpeed_t clkSpeed;
    logic      ready;
    logic      riseTick;
    logic      fallTick;
    respType_t respType;

    // ==============================
    // Configuration and card clock
    // ==============================
    sdConfigRegs cfgRegs (
        .clk_fast (clk_fast),
        .rstN     (rstN),
        .cfgWrite (cfgWrite),
        .cfgReq   (cfgReq),
        .clkRun   (clkRun),
        .clkSpeed (clkSpeed),
        .ready    (ready)
    );

    sdClockGen clkGen (
        .clk_fast (clk_fast),
        .rstN     (rstN),
        .clkRun   (clkRun),
        .clkSpeed (clkSpeed),
        .sdClk    (sdClk),
        .riseTick (riseTick),
        .fallTick (fallTick)
    );

    // ==============================
    // CMD line engines
    // ==============================
    sdCmdTx cmdTx (
        .clk_fast (clk_fast),
        .rstN     (rstN),
        .ready    (ready),
        .fallTick (fallTick),
        .cmdStart (cmdStart),
        .cmdReq   (cmdReq),
        .sdCmdOut (sdCmdOut),
        .sdCmdOe  (sdCmdOe),
        .cmdDone  (cmdDone),
        .respType (respType)
    );

    sdRespRx respRx (
        .clk_fast   (clk_fast),
        .rstN       (rstN),
        .ready      (ready),
        .riseTick   (riseTick),
        .cmdDone    (cmdDone),
        .respType   (respType),
        .sdCmdIn    (sdCmdIn),
        .respDone   (respDone),
        .respResult (respResult)
    );

    // Receiver only listens once the transmitter has released the line
    rxNotWhileDriving: assert property (@(posedge clk_fast) disable iff (!rstN)
        respRx.armed |-> !sdCmdOe);

endmodule

`default_nettype wire

//--- bench/tbClock.sv
`default_nettype none
`timescale 1ns/100ps

module tbClock (
    output logic clk_fast,
    output logic rstN
);

    localparam int HalfPeriodNs = 10;
    localparam int ResetCycles  = 4;

    initial begin
        clk_fast = 1'b0;
        forever #(HalfPeriodNs) clk_fast = ~clk_fast;
    end

    // Reset released just after a rising edge like every other input
    initial begin
        rstN = 1'b0;
        repeat (ResetCycles) @(posedge clk_fast);
        #2;
        rstN = 1'b1;
    end

endmodule

`default_nettype wire

//--- bench/sdControllerTb.sv
`default_nettype none
`timescale 1ns/100ps

module sdControllerTb
    import sdCfgPkg::*;
    import sdCmdPkg::*;
();

    localparam int ClkPeriodNs = 20;
    localparam int SlowCardNs  = 2 * int'(SlowHalfPeriod) * ClkPeriodNs;
    localparam int WaitLimit   = (CmdLen + LongRespLen + 16) * 2 * int'(SlowHalfPeriod);
    localparam int NumCmds     = 16;
    localparam int WatchdogNs  = NumCmds * (CmdLen + LongRespLen + 16) * SlowCardNs + 200000;
    localparam int LongBodyLen = LongRespLen - LongCrcSkip - Crc7Len - 1;
    localparam int FaultNone   = 0;
    localparam int FaultCrc    = 1;
    localparam int FaultEnd    = 2;

    logic        clk_fast;
    logic        rstN;
    logic        cfgWrite;
    cfgReq_t     cfgReq;
    logic        cmdStart;
    cmdReq_t     cmdReq;
    logic        cmdDone;
    logic        respDone;
    respResult_t respResult;
    logic        sdClk;
    logic        sdCmdOut;
    logic        sdCmdOe;
    logic        sdCmdIn;

    int                     seed;
    int                     cmdDoneCount;
    int                     respDoneCount;
    int                     cmdsIssued;
    int                     respsExpected;
    logic [LongRespLen-1:0] cardResp;
    int                     cardRespLen;
    logic                   cardBusy;
    logic [CmdLen-1:0]      expFrames[$];
    logic [CmdLen-1:0]      gotFrames[$];
    respResult_t            expResps[$];

    tbClock clkRst (
        .clk_fast (clk_fast),
        .rstN     (rstN)
    );

    sdController dut0 (
        .clk_fast   (clk_fast),
        .rstN       (rstN),
        .cfgWrite   (cfgWrite),
        .cfgReq     (cfgReq),
        .cmdStart   (cmdStart),
        .cmdReq     (cmdReq),
        .cmdDone    (cmdDone),
        .respDone   (respDone),
        .respResult (respResult),
        .sdClk      (sdClk),
        .sdCmdOut   (sdCmdOut),
        .sdCmdOe    (sdCmdOe),
        .sdCmdIn    (sdCmdIn)
    );

    // ==============================
    // Reference model and checking
    // ==============================
    // CRC7 with x^7 + x^3 + 1 over the low len bits MSB first
    function automatic logic [6:0] crc7Ref(input logic [LongRespLen-1:0] bits, input int len);
        logic [6:0] r;
        logic       inv;
        int         i;
        r = '0;
        for (i = len - 1; i >= 0; i--) begin
            inv = bits[i] ^ r[6];
            r = {r[5:3], r[2] ^ inv, r[1:0], inv};
        end
        return r;
    endfunction

    task automatic stopWithFailure(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic compareValue(input string name, input logic [LongRespLen:0] got,
                                input logic [LongRespLen:0] exp);
        if (got !== exp) begin
            stopWithFailure($sformatf("ERR %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    always @(negedge clk_fast) begin : compareResults
        respResult_t want;
        if (rstN) begin
            if (cmdDone) begin
                cmdDoneCount++;
            end
            if (respDone) begin
                respDoneCount++;
                if (expResps.size() == 0) begin
                    stopWithFailure("respDone pulsed while no response was expected");
                end else begin
                    want = expResps.pop_front();
                    compareValue("respResult.data", respResult.data, want.data);
                    compareValue("respResult.crcErr", respResult.crcErr, want.crcErr);
                end
            end
            if (gotFrames.size() != 0) begin
                if (expFrames.size() == 0) begin
                    stopWithFailure("Card saw a command frame that was never started");
                end else begin
                    compareValue("cmdFrame", gotFrames.pop_front(), expFrames.pop_front());
                end
            end
        end
    end

    // ==============================
    // Card model
    // ==============================
    // Response starts on the third falling card clock after the end bit
    task automatic sendResponse();
        int i;
        cardBusy = 1'b1;
        repeat (3) @(negedge sdClk);
        for (i = cardRespLen - 1; i >= 0; i--) begin
            #2;
            sdCmdIn = cardResp[i];
            @(negedge sdClk);
        end
        #2;
        sdCmdIn  = 1'b1;
        cardBusy = 1'b0;
    endtask

    initial begin : cardModel
        logic [CmdLen-1:0] rxFrame;
        int                nBits;
        rxFrame = '0;
        nBits   = 0;
        forever begin
            @(posedge sdClk);
            #1;
            if (sdCmdOe) begin
                rxFrame = {rxFrame[CmdLen-2:0], sdCmdOut};
                nBits++;
                if (nBits == CmdLen) begin
                    gotFrames.push_back(rxFrame);
                    nBits = 0;
                    if (cardRespLen != 0) begin
                        sendResponse();
                    end
                end
            end
        end
    end

    // ==============================
    // Stimulus helpers
    // ==============================
    task automatic waitForPulse(input bit wantResp);
        int waited;
        bit seen;
        waited = 0;
        seen   = 1'b0;
        while (!seen) begin
            @(negedge clk_fast);
            seen = wantResp ? respDone : cmdDone;
            waited++;
            if (!seen && waited > WaitLimit) begin
                stopWithFailure($sformatf("No %s arrived within %0d cycles",
                                          wantResp ? "respDone" : "cmdDone", WaitLimit));
            end
        end
    endtask

    task automatic waitCardIdle();
        int waited;
        waited = 0;
        while (cardBusy) begin
            @(negedge clk_fast);
            waited++;
            if (waited > WaitLimit) begin
                stopWithFailure("Card model was still sending a response after the wait limit");
            end
        end
    endtask

    task automatic writeConfig(input cfgAction_t action, input clkSpeed_t speed);
        @(posedge clk_fast);
        #2;
        cfgWrite        = 1'b1;
        cfgReq.action   = action;
        cfgReq.clkSpeed = speed;
        @(posedge clk_fast);
        #2;
        cfgWrite = 1'b0;
        // Card clock must stay low while the new setting settles
        repeat (2 * SettleCycles) begin
            @(negedge clk_fast);
            compareValue("sdClk", sdClk, 1'b0);
        end
    endtask

    task automatic measureHalfPeriod(input int expCycles);
        time tRise;
        time tFall;
        @(posedge sdClk);
        tRise = $time;
        @(negedge sdClk);
        tFall = $time;
        compareValue("sdClkHalfPeriod", (tFall - tRise) / ClkPeriodNs, expCycles);
    endtask

    // Without ready the transmitter must not touch the line
    task automatic expectStartIgnored();
        @(posedge clk_fast);
        #2;
        cmdReq.data     = {$random(seed), $random(seed)};
        cmdReq.respType = RespShort;
        cmdStart        = 1'b1;
        @(posedge clk_fast);
        #2;
        cmdStart = 1'b0;
        repeat (CmdLen * 2 * int'(SlowHalfPeriod) + 20) begin
            @(negedge clk_fast);
            compareValue("sdCmdOe", sdCmdOe, 1'b0);
            compareValue("cmdDone", cmdDone, 1'b0);
        end
    endtask

    task automatic runCommand(input respType_t kind, input int fault);
        logic [127:0]               wide;
        logic [CmdLen-1:0]          cmdData;
        logic [CmdPayloadLen-1:0]   body;
        logic [LongBodyLen-1:0]     longBody;
        logic [LongRespLen-1:0]     resp;
        respResult_t                want;
        wide     = {$random(seed), $random(seed), $random(seed), $random(seed)};
        cmdData  = {2'b01, wide[69:64], wide[31:0], wide[79:72]};
        expFrames.push_back({cmdData[CmdLen-1:CmdLen-CmdPayloadLen],
                             crc7Ref(cmdData[CmdLen-1:CmdLen-CmdPayloadLen], CmdPayloadLen),
                             1'b1});

        // Long frames carry a CRC over everything after the first byte
        if (kind == RespLong) begin
            wide        = {$random(seed), $random(seed), $random(seed), $random(seed)};
            longBody    = wide[LongBodyLen-1:0];
            resp        = {8'h3F, longBody, crc7Ref(longBody, LongBodyLen), 1'b1};
            cardRespLen = LongRespLen;
        end else begin
            body        = {2'b00, wide[101:96], wide[63:32]};
            resp        = {body, crc7Ref(body, CmdPayloadLen), 1'b1};
            cardRespLen = ShortRespLen;
        end
        if (fault == FaultCrc) begin
            resp[4] = ~resp[4];
        end else if (fault == FaultEnd) begin
            resp[0] = 1'b0;
        end
        cardResp = resp;

        // With no response type the card still answers and the DUT must ignore it
        if (kind != RespNone) begin
            want.data   = resp;
            want.crcErr = (fault != FaultNone);
            expResps.push_back(want);
            respsExpected++;
        end

        @(posedge clk_fast);
        #2;
        cmdReq.data     = cmdData;
        cmdReq.respType = kind;
        cmdStart        = 1'b1;
        @(posedge clk_fast);
        #2;
        cmdStart = 1'b0;
        cmdsIssued++;

        waitForPulse(1'b0);
        if (kind != RespNone) begin
            waitForPulse(1'b1);
        end
        waitCardIdle();
        repeat (2) @(negedge clk_fast);
        compareValue("cmdDoneCount", cmdDoneCount, cmdsIssued);
        compareValue("respDoneCount", respDoneCount, respsExpected);
        compareValue("pendingFrames", expFrames.size(), 0);
    endtask

    task automatic runCommandSet();
        runCommand(RespShort, FaultNone);
        runCommand(RespShort, FaultNone);
        runCommand(RespLong, FaultNone);
        runCommand(RespNone, FaultNone);
        runCommand(RespLong, FaultNone);
        runCommand(RespShort, FaultCrc);
        runCommand(RespShort, FaultEnd);
        runCommand(RespLong, FaultCrc);
    endtask

    // ==============================
    // Main sequence and watchdog
    // ==============================
    initial begin : stimulus
        seed          = 60;
        cmdDoneCount  = 0;
        respDoneCount = 0;
        cmdsIssued    = 0;
        respsExpected = 0;
        cardResp      = '0;
        cardRespLen   = 0;
        cardBusy      = 1'b0;
        cfgWrite      = 1'b0;
        cfgReq        = '0;
        cmdStart      = 1'b0;
        cmdReq        = '0;
        sdCmdIn       = 1'b1;
        @(posedge rstN);

        expectStartIgnored();
        measureHalfPeriod(int'(SlowHalfPeriod));

        writeConfig(CfgInit, ClkFast);
        measureHalfPeriod(int'(FastHalfPeriod));
        runCommandSet();

        // Reset action forces slow speed whatever speed is requested
        writeConfig(CfgReset, ClkFast);
        measureHalfPeriod(int'(SlowHalfPeriod));
        cardRespLen = 0;
        expectStartIgnored();

        writeConfig(CfgInit, ClkSlow);
        measureHalfPeriod(int'(SlowHalfPeriod));
        runCommandSet();

        compareValue("pendingResponses", expResps.size(), 0);
        $display("Simulation completed successfully");
        $finish;
    end

    initial begin : watchdog
        #(WatchdogNs);
        stopWithFailure("Timeout: the tests did not finish in the expected time");
    end

endmodule

`default_nettype wire

//--- files.f
design/sdCfgPkg.sv
design/sdCmdPkg.sv
design/sdCrc7.sv
design/sdClockGen.sv
design/sdConfigRegs.sv
design/sdCmdTx.sv
design/sdRespRx.sv
design/sdController.sv
bench/tbClock.sv
bench/sdControllerTb.sv

//--- Bender.yml
package:
  name: sdController

sources:
  - files:
      - design/sdCfgPkg.sv
      - design/sdCmdPkg.sv
      - design/sdCrc7.sv
      - design/sdClockGen.sv
      - design/sdConfigRegs.sv
      - design/sdCmdTx.sv
      - design/sdRespRx.sv
      - design/sdController.sv
  - target: test
    files:
      - bench/tbClock.sv
      - bench/sdControllerTb.sv
